// File: files.f
source/dga_pkg.sv
source/dga_cmd_capture.sv
source/dga_strobe_slice.sv
source/dga_signal_driver.sv
source/dga_decode_top.sv
verification/dga_assert.sv
verification/dga_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --timescale 1ns/100ps \
   --top-module dga_tb \
   -f files.f

# The simulator status alone does not decide the result
./obj_dir/Vdga_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
   echo "run_sim: PASS"
else
   echo "run_sim: FAIL"
   exit 1
fi

// File: verification/dga_tb.sv
// Testbench for the databus command decoder
// Seeded random commands checked against a cycle model of the decode pipeline
`default_nettype none

module dga_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int num_cmds      = 5000;
   localparam int reset_cycles  = 10;
   localparam int reset_timeout = 20;
   localparam logic [31:0] seed = 32'hf780_95fe;

   logic clk2;
   logic rst_n;
   logic [4:0] cscomm;
   logic [1:0] csmis;
   logic lcs_n;
   logic clear;
   logic eorf_n;
   logic idbi5;
   logic idbi7;

   logic iorq_n, rwcs_n, short_n, sioc_n, clrti_n, empid_n, start_n, ldpanc_n;
   logic wchim_n, fetch, write, form_n, dt_n, mreq, emcl_n, reset;

   // Model state
   dga_pkg::strobe_vec_t strobe_q[$];
   logic [1:0]           dbus_q[$];
   dga_pkg::cmd_t        cmd_now;
   logic                 exp_emcl_n;
   logic                 exp_reset;
   logic                 prev_clear;
   logic                 prev_sioc;
   logic [1:0]           prev_dbus;
   int                   hits[dga_pkg::n_strobes];
   int                   sioc_loads;

   dga_decode_top dut (
      .clk2     (clk2),
      .rst_n    (rst_n),
      .cscomm   (cscomm),
      .csmis    (csmis),
      .lcs_n    (lcs_n),
      .clear    (clear),
      .eorf_n   (eorf_n),
      .idbi5    (idbi5),
      .idbi7    (idbi7),
      .iorq_n   (iorq_n),
      .rwcs_n   (rwcs_n),
      .short_n  (short_n),
      .sioc_n   (sioc_n),
      .clrti_n  (clrti_n),
      .empid_n  (empid_n),
      .start_n  (start_n),
      .ldpanc_n (ldpanc_n),
      .wchim_n  (wchim_n),
      .fetch    (fetch),
      .write    (write),
      .form_n   (form_n),
      .dt_n     (dt_n),
      .mreq     (mreq),
      .emcl_n   (emcl_n),
      .reset    (reset)
   );

   initial begin
      clk2 = 1'b0;
      forever #4 clk2 = ~clk2;
   end

   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk2);
      #1 rst_n = 1'b1;
   end

   task automatic stop_with_failure();
      $display("Regression failed");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_strobes(input string name, input dga_pkg::strobe_vec_t expected,
                                input dga_pkg::strobe_vec_t actual);
      if (actual !== expected) begin
         $display("error: time %0t, %s expected %b, actual %b", $time, name, expected, actual);
         stop_with_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("error: time %0t, %s expected %b, actual %b", $time, name, expected, actual);
         stop_with_failure();
      end
   endtask

   // Decode table, csmis then cscomm
   function automatic dga_pkg::strobe_vec_t reference_decode(input dga_pkg::cmd_t c);
      dga_pkg::strobe_vec_t v;
      v = '0;
      casez (c)
         7'b1?_11111: v[dga_pkg::iorq_idx]   = 1'b1;
         7'b01_11110: v[dga_pkg::rwcs_idx]   = 1'b1;
         7'b??_00111: v[dga_pkg::sioc_idx]   = 1'b1;
         7'b??_01101: v[dga_pkg::clrti_idx]  = 1'b1;
         7'b??_01010: v[dga_pkg::empid_idx]  = 1'b1;
         7'b??_01011: v[dga_pkg::start_idx]  = 1'b1;
         7'b10_00110: v[dga_pkg::ldpanc_idx] = 1'b1;
         7'b00_10001: v[dga_pkg::wchim_idx]  = 1'b1;
         7'b??_101??: v[dga_pkg::fetch_idx]  = 1'b1;
         7'b??_1101?: v[dga_pkg::write_idx]  = 1'b1;
         7'b??_10011: v[dga_pkg::form_idx]   = 1'b1;
         7'b??_1100?: v[dga_pkg::dt_idx]     = 1'b1;
         default: ;
      endcase
      return v;
   endfunction

   // A table command with its don't-care bits filled from r
   function automatic dga_pkg::cmd_t table_command(input int idx, input logic [31:0] r);
      dga_pkg::cmd_t c;
      case (idx)
         0:       c = {1'b1, r[0], 5'b11111};
         1:       c = 7'b01_11110;
         2:       c = {r[1:0], 5'b00111};
         3:       c = {r[1:0], 5'b01101};
         4:       c = {r[1:0], 5'b01010};
         5:       c = {r[1:0], 5'b01011};
         6:       c = 7'b10_00110;
         7:       c = 7'b00_10001;
         8:       c = {r[1:0], 3'b101, r[3:2]};
         9:       c = {r[1:0], 4'b1101, r[2]};
         10:      c = {r[1:0], 5'b10011};
         default: c = {r[1:0], 4'b1100, r[2]};
      endcase
      return c;
   endfunction

   task automatic drive_inputs(input bit idle);
      logic [31:0] r;
      r = $urandom;
      if (r[3]) begin
         cmd_now = table_command($urandom % 12, $urandom);
      end else begin
         cmd_now = r[14:8];
      end
      cscomm = cmd_now[4:0];
      csmis  = cmd_now[6:5];
      eorf_n = r[0];
      idbi5  = r[1];
      idbi7  = r[2];
      if (idle) begin
         lcs_n = 1'b0;
         clear = 1'b0;
      end else begin
         // Mostly enabled so that enough commands decode
         lcs_n = ($urandom % 8) != 0;
         clear = ($urandom % 8) == 0;
      end
   endtask

   function automatic dga_pkg::strobe_vec_t pins_to_strobes();
      dga_pkg::strobe_vec_t v;
      v[dga_pkg::iorq_idx]   = ~iorq_n;
      v[dga_pkg::rwcs_idx]   = ~rwcs_n;
      v[dga_pkg::sioc_idx]   = ~sioc_n;
      v[dga_pkg::clrti_idx]  = ~clrti_n;
      v[dga_pkg::empid_idx]  = ~empid_n;
      v[dga_pkg::start_idx]  = ~start_n;
      v[dga_pkg::ldpanc_idx] = ~ldpanc_n;
      v[dga_pkg::wchim_idx]  = ~wchim_n;
      v[dga_pkg::fetch_idx]  = fetch;
      v[dga_pkg::write_idx]  = write;
      v[dga_pkg::form_idx]   = ~form_n;
      v[dga_pkg::dt_idx]     = ~dt_n;
      return v;
   endfunction

   task automatic check_outputs(input dga_pkg::strobe_vec_t exp_s);
      dga_pkg::strobe_vec_t pin_exp;
      pin_exp = exp_s;
      // empid and ldpanc only reach the pins during end of read field
      pin_exp[dga_pkg::empid_idx]  = exp_s[dga_pkg::empid_idx] & ~eorf_n;
      pin_exp[dga_pkg::ldpanc_idx] = exp_s[dga_pkg::ldpanc_idx] & ~eorf_n;
      check_strobes("strobe pins", pin_exp, pins_to_strobes());
      check_bit("mreq", exp_s[dga_pkg::fetch_idx] | exp_s[dga_pkg::write_idx] |
                exp_s[dga_pkg::form_idx], mreq);
      check_bit("short_n", ~(exp_s[dga_pkg::iorq_idx] | exp_s[dga_pkg::rwcs_idx]), short_n);
      check_bit("emcl_n", exp_emcl_n, emcl_n);
      check_bit("reset", exp_reset, reset);
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (rst_n !== 1'b1) begin
         if (cycles >= reset_timeout) begin
            $display("reset was not released within %0d cycles", reset_timeout);
            stop_with_failure();
         end
         @(posedge clk2);
         #2;
         cycles++;
      end
   endtask

   initial begin
      dga_pkg::strobe_vec_t exp_s;
      logic [1:0]           exp_dbus;
      int                   missing;

      void'($urandom(seed));
      cscomm = '0;
      csmis  = '0;
      lcs_n  = 1'b0;
      clear  = 1'b0;
      eorf_n = 1'b1;
      idbi5  = 1'b0;
      idbi7  = 1'b0;
      exp_emcl_n = 1'b1;
      exp_reset  = 1'b0;
      prev_clear = 1'b0;
      prev_sioc  = 1'b0;
      prev_dbus  = '0;
      sioc_loads = 0;
      for (int k = 0; k < dga_pkg::n_strobes; k++) begin
         hits[k] = 0;
      end
      // Two empty pipeline stages ahead of the first command
      repeat (2) begin
         strobe_q.push_back('0);
         dbus_q.push_back(2'b00);
      end

      wait_reset_release();
      check_outputs('0);

      for (int n = 0; n < num_cmds + 2; n++) begin
         @(posedge clk2);
         // Control latches at this edge
         if (prev_clear) begin
            exp_emcl_n = 1'b1;
            exp_reset  = 1'b0;
         end else if (prev_sioc) begin
            exp_emcl_n = prev_dbus[0];
            exp_reset  = prev_dbus[1];
            sioc_loads++;
         end
         #1;
         drive_inputs(n >= num_cmds);
         strobe_q.push_back((lcs_n && !clear) ? reference_decode(cmd_now) : '0);
         dbus_q.push_back({idbi7, idbi5});
         exp_s    = strobe_q.pop_front();
         exp_dbus = dbus_q.pop_front();
         #3;
         check_outputs(exp_s);
         for (int k = 0; k < dga_pkg::n_strobes; k++) begin
            if (exp_s[k]) hits[k]++;
         end
         prev_clear = clear;
         prev_sioc  = exp_s[dga_pkg::sioc_idx];
         prev_dbus  = exp_dbus;
      end

      missing = 0;
      for (int k = 0; k < dga_pkg::n_strobes; k++) begin
         if (hits[k] == 0) missing++;
      end
      if (missing == 0 && sioc_loads > 0) begin
         $display("%0d commands checked, %0d control latch loads", num_cmds, sioc_loads);
         $display("Regression passed");
         $finish;
      end else begin
         $display("%0d decode strobes were never exercised", missing);
         stop_with_failure();
      end
   end

endmodule

`default_nettype wire

// File: verification/dga_assert.sv
// Assertions for the databus command decoder
// Strobe exclusivity, the memory request rule and quiet outputs after reset
`default_nettype none

module dga_assert (
   input wire                  clk2,
   input wire                  rst_n,
   input dga_pkg::cmd_t        cmd,
   input wire                  cmd_valid,
   input dga_pkg::strobe_vec_t strobes,
   input wire                  mreq,
   input wire                  emcl_n,
   input wire                  reset
);
   timeunit 1ns;
   timeprecision 100ps;

   // Table entries never overlap
   strobe_onehot: assert property (@(posedge clk2) disable iff (!rst_n)
      $onehot0(strobes))
      else $error("more than one decode strobe active: %b", strobes);

   // Memory request one cycle after a qualified fetch, write or form command
   mreq_rule: assert property (@(posedge clk2) disable iff (!rst_n)
      mreq == $past(cmd_valid && (cmd[4:2] == 3'b101 || cmd[4:1] == 4'b1101 ||
                                  cmd[4:0] == 5'b10011)))
      else $error("mreq does not follow a decoded fetch, write or form command");

   // Cycle after the first edge with reset released
   reset_quiet: assert property (@(posedge clk2)
      ($past(rst_n) && !$past(rst_n, 2)) |-> (strobes == '0 && emcl_n && !reset))
      else $error("strobe or control latch active right after reset");

endmodule

bind dga_decode_top dga_assert u_assert (
   .clk2      (clk2),
   .rst_n     (rst_n),
   .cmd       (cmd),
   .cmd_valid (cmd_valid),
   .strobes   (strobes),
   .mreq      (mreq),
   .emcl_n    (emcl_n),
   .reset     (reset)
);

`default_nettype wire

// File: source/dga_decode_top.sv
// Internal databus command decoder, top level
// Capture stage, one decode slice per table entry, and the output drive stage
`default_nettype none

module dga_decode_top (
   input  wire        clk2,
   input  wire        rst_n,
   input  wire  [4:0] cscomm,
   input  wire  [1:0] csmis,
   input  wire        lcs_n,
   input  wire        clear,
   input  wire        eorf_n,
   input  wire        idbi5,
   input  wire        idbi7,
   output logic       iorq_n,
   output logic       rwcs_n,
   output logic       short_n,
   output logic       sioc_n,
   output logic       clrti_n,
   output logic       empid_n,
   output logic       start_n,
   output logic       ldpanc_n,
   output logic       wchim_n,
   output logic       fetch,
   output logic       write,
   output logic       form_n,
   output logic       dt_n,
   output logic       mreq,
   output logic       emcl_n,
   output logic       reset
);

   dga_pkg::cmd_t        cmd;
   logic                 cmd_valid;
   logic [1:0]           dbus_bits;
   dga_pkg::strobe_vec_t strobes;

   dga_cmd_capture u_capture (
      .clk2      (clk2),
      .rst_n     (rst_n),
      .cscomm    (cscomm),
      .csmis     (csmis),
      .lcs_n     (lcs_n),
      .clear     (clear),
      .idbi5     (idbi5),
      .idbi7     (idbi7),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .dbus_bits (dbus_bits)
   );

   // One slice per decode table entry
   for (genvar i = 0; i < dga_pkg::n_strobes; i++) begin : g_slice
      dga_strobe_slice #(
         .match_code (dga_pkg::decode_code[i]),
         .match_mask (dga_pkg::decode_mask[i])
      ) u_slice (
         .clk2      (clk2),
         .rst_n     (rst_n),
         .cmd       (cmd),
         .cmd_valid (cmd_valid),
         .strobe    (strobes[i])
      );
   end

   dga_signal_driver u_driver (
      .clk2      (clk2),
      .rst_n     (rst_n),
      .clear     (clear),
      .eorf_n    (eorf_n),
      .strobes   (strobes),
      .dbus_bits (dbus_bits),
      .iorq_n    (iorq_n),
      .rwcs_n    (rwcs_n),
      .short_n   (short_n),
      .sioc_n    (sioc_n),
      .clrti_n   (clrti_n),
      .empid_n   (empid_n),
      .start_n   (start_n),
      .ldpanc_n  (ldpanc_n),
      .wchim_n   (wchim_n),
      .fetch     (fetch),
      .write     (write),
      .form_n    (form_n),
      .dt_n      (dt_n),
      .mreq      (mreq),
      .emcl_n    (emcl_n),
      .reset     (reset)
   );

endmodule

`default_nettype wire

// File: source/dga_signal_driver.sv
// Output drive stage of the databus command decoder
// Active-low pins, memory request, end-of-field gating and the emcl/reset control latches
`default_nettype none

module dga_signal_driver (
   input  wire                  clk2,
   input  wire                  rst_n,
   input  wire                  clear,
   input  wire                  eorf_n,
   input  dga_pkg::strobe_vec_t strobes,
   input  wire  [1:0]           dbus_bits,
   output logic                 iorq_n,
   output logic                 rwcs_n,
   output logic                 short_n,
   output logic                 sioc_n,
   output logic                 clrti_n,
   output logic                 empid_n,
   output logic                 start_n,
   output logic                 ldpanc_n,
   output logic                 wchim_n,
   output logic                 fetch,
   output logic                 write,
   output logic                 form_n,
   output logic                 dt_n,
   output logic                 mreq,
   output logic                 emcl_n,
   output logic                 reset
);

   // Databus bits one stage later, in step with the strobes
   logic [1:0] dbus_bits_d;

   // End of read field, active high
   logic       eorf;

   assign eorf = ~eorf_n;

   // Plain inversions to the pins
   assign iorq_n  = ~strobes[dga_pkg::iorq_idx];
   assign rwcs_n  = ~strobes[dga_pkg::rwcs_idx];
   assign sioc_n  = ~strobes[dga_pkg::sioc_idx];
   assign clrti_n = ~strobes[dga_pkg::clrti_idx];
   assign start_n = ~strobes[dga_pkg::start_idx];
   assign wchim_n = ~strobes[dga_pkg::wchim_idx];
   assign form_n  = ~strobes[dga_pkg::form_idx];
   assign dt_n    = ~strobes[dga_pkg::dt_idx];

   // Short bus cycle for I/O and control-store access
   assign short_n = ~(strobes[dga_pkg::iorq_idx] | strobes[dga_pkg::rwcs_idx]);

   // Only active during the end of the read field
   assign empid_n  = ~(strobes[dga_pkg::empid_idx] & eorf);
   assign ldpanc_n = ~(strobes[dga_pkg::ldpanc_idx] & eorf);

   assign fetch = strobes[dga_pkg::fetch_idx];
   assign write = strobes[dga_pkg::write_idx];

   // Memory request for any memory cycle
   assign mreq = strobes[dga_pkg::fetch_idx] |
                 strobes[dga_pkg::write_idx] |
                 strobes[dga_pkg::form_idx];

   always_ff @(posedge clk2) begin
      dbus_bits_d <= dbus_bits;
   end

   // I/O control latches, loaded by sioc and dropped by clear
   always_ff @(posedge clk2 or negedge rst_n) begin
      if (!rst_n) begin
         emcl_n <= 1'b1;
         reset  <= 1'b0;
      end else if (clear) begin
         emcl_n <= 1'b1;
         reset  <= 1'b0;
      end else if (strobes[dga_pkg::sioc_idx]) begin
         // idbi5 in bit 0, idbi7 in bit 1
         emcl_n <= dbus_bits_d[0];
         reset  <= dbus_bits_d[1];
      end
   end

endmodule

`default_nettype wire

// File: source/dga_strobe_slice.sv
// Single command decode slice
// Masked compare against one table entry, registered as a strobe
`default_nettype none

module dga_strobe_slice #(
   parameter dga_pkg::cmd_t match_code = '0,
   parameter dga_pkg::cmd_t match_mask = '0
) (
   input  wire              clk2,
   input  wire              rst_n,
   input  dga_pkg::cmd_t    cmd,
   input  wire              cmd_valid,
   output logic             strobe
);

   logic hit;

   // Only the masked bits take part
   assign hit = ((cmd & match_mask) == (match_code & match_mask));

   always_ff @(posedge clk2 or negedge rst_n) begin
      if (!rst_n) begin
         strobe <= 1'b0;
      end else begin
         strobe <= cmd_valid & hit;
      end
   end

endmodule

`default_nettype wire

// File: source/dga_cmd_capture.sv
// Command capture stage
// Builds the 7-bit microcode command and its decode qualifier, with databus bits alongside
`default_nettype none

module dga_cmd_capture (
   input  wire              clk2,
   input  wire              rst_n,
   input  wire  [4:0]       cscomm,
   input  wire  [1:0]       csmis,
   input  wire              lcs_n,
   input  wire              clear,
   input  wire              idbi5,
   input  wire              idbi7,
   output dga_pkg::cmd_t    cmd,
   output logic             cmd_valid,
   output logic [1:0]       dbus_bits
);

   // Decode only outside a control-store load and while not clearing
   always_ff @(posedge clk2 or negedge rst_n) begin
      if (!rst_n) begin
         cmd_valid <= 1'b0;
      end else begin
         cmd_valid <= lcs_n & ~clear;
      end
   end

   // Command and databus payload, qualified by cmd_valid downstream
   always_ff @(posedge clk2) begin
      cmd       <= {csmis, cscomm};
      dbus_bits <= {idbi7, idbi5};
   end

endmodule

`default_nettype wire

// File: source/dga_pkg.sv
// Decode gate array shared definitions
// Command word layout, strobe numbering and the command decode table
`default_nettype none

package dga_pkg;

   // Command word is {csmis[1:0], cscomm[4:0]}
   localparam int cmd_w = 7;

   typedef logic [cmd_w-1:0] cmd_t;

   localparam int n_strobes = 12;

   // One bit per decoded command, active high
   typedef logic [n_strobes-1:0] strobe_vec_t;

   // Strobe positions in strobe_vec_t and in the decode tables
   localparam int iorq_idx   = 0;
   localparam int rwcs_idx   = 1;
   localparam int sioc_idx   = 2;
   localparam int clrti_idx  = 3;
   localparam int empid_idx  = 4;
   localparam int start_idx  = 5;
   localparam int ldpanc_idx = 6;
   localparam int wchim_idx  = 7;
   localparam int fetch_idx  = 8;
   localparam int write_idx  = 9;
   localparam int form_idx   = 10;
   localparam int dt_idx     = 11;

   // Match value per strobe, don't-care bits held at zero
   localparam cmd_t decode_code [n_strobes] = '{
      7'b10_11111,   // iorq
      7'b01_11110,   // rwcs
      7'b00_00111,   // sioc
      7'b00_01101,   // clrti
      7'b00_01010,   // empid
      7'b00_01011,   // start
      7'b10_00110,   // ldpanc
      7'b00_10001,   // wchim
      7'b00_10100,   // fetch
      7'b00_11010,   // write
      7'b00_10011,   // form
      7'b00_11000    // dt
   };

   // Bits that take part in each compare
   localparam cmd_t decode_mask [n_strobes] = '{
      7'b10_11111,   // iorq, csmis[0] free
      7'b11_11111,   // rwcs
      7'b00_11111,   // sioc
      7'b00_11111,   // clrti
      7'b00_11111,   // empid
      7'b00_11111,   // start
      7'b11_11111,   // ldpanc
      7'b11_11111,   // wchim
      7'b00_11100,   // fetch
      7'b00_11110,   // write
      7'b00_11111,   // form
      7'b00_11110    // dt
   };

endpackage

`default_nettype wire
